/* hdl/soc_pkg.sv */
package soc_pkg;

    // CPU side bus, sampled on clk_2
    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rwb;    // 1 read, 0 write
    } cpu_bus_t;

    typedef enum logic [2:0] {
        REGION_NONE,
        REGION_ROM,
        REGION_TIMER,
        REGION_MULT,
        REGION_IRQ
    } region_e;

    // Memory map
    localparam logic [15:0] ROM_BASE   = 16'hF000;    // Window up to FFFF

    localparam logic [15:0] TIMER_BASE = 16'hC000;
    localparam logic [15:0] TIMER_SIZE = 16'd4;

    localparam logic [15:0] MULT_BASE  = 16'hC008;
    localparam logic [15:0] MULT_SIZE  = 16'd8;

    localparam logic [15:0] IRQ_BASE   = 16'hC010;
    localparam logic [15:0] IRQ_SIZE   = 16'd2;

    // Peripherals see only their offset bits, so each
    // block must sit on a boundary of its own size

endpackage

/* hdl/bus_decode.sv */
`timescale 1ns/1ps

module bus_decode (
    input  logic              clk_2,
    input  logic              i_reset,
    input  soc_pkg::cpu_bus_t i_bus,
    output logic              o_rom_cs,
    output logic              o_timer_cs,
    output logic              o_mult_cs,
    output logic              o_irq_cs,
    input  logic [7:0]        i_rom_rdata,
    input  logic [7:0]        i_timer_rdata,
    input  logic [7:0]        i_mult_rdata,
    input  logic [7:0]        i_irq_rdata,
    output logic [7:0]        o_rdata
);
    import soc_pkg::*;

    region_e region;
    region_e region_q;    // Region of the read issued last cycle

    always_comb begin
        region = REGION_NONE;
        if (i_bus.addr >= ROM_BASE)
            region = REGION_ROM;
        else if (i_bus.addr >= TIMER_BASE && i_bus.addr < TIMER_BASE + TIMER_SIZE)
            region = REGION_TIMER;
        else if (i_bus.addr >= MULT_BASE && i_bus.addr < MULT_BASE + MULT_SIZE)
            region = REGION_MULT;
        else if (i_bus.addr >= IRQ_BASE && i_bus.addr < IRQ_BASE + IRQ_SIZE)
            region = REGION_IRQ;
    end

    assign o_rom_cs   = (region == REGION_ROM);
    assign o_timer_cs = (region == REGION_TIMER);
    assign o_mult_cs  = (region == REGION_MULT);
    assign o_irq_cs   = (region == REGION_IRQ);

    always_ff @(posedge clk_2) begin
        if (i_reset)
            region_q <= REGION_NONE;
        else
            region_q <= i_bus.rwb ? region : REGION_NONE;
    end

    always_comb begin
        case (region_q)
            REGION_ROM:   o_rdata = i_rom_rdata;
            REGION_TIMER: o_rdata = i_timer_rdata;
            REGION_MULT:  o_rdata = i_mult_rdata;
            REGION_IRQ:   o_rdata = i_irq_rdata;
            default:      o_rdata = 8'h00;    // Unmapped reads as 0
        endcase
    end

endmodule

/* hdl/boot_rom.sv */
`timescale 1ns/1ps

module boot_rom #(
    parameter int ROM_ADDR_WIDTH = 5
) (
    input  logic              clk_2,
    input  logic              i_cs,
    input  soc_pkg::cpu_bus_t i_bus,
    output logic [7:0]        o_rdata
);

    logic [7:0] rom_mem [0:(2**ROM_ADDR_WIDTH)-1];

    initial begin
        $readmemh("boot_rom.hex", rom_mem);
    end

    // Upper address bits are ignored, so the image repeats across the window
    always_ff @(posedge clk_2) begin
        if (i_cs && i_bus.rwb) begin
            o_rdata <= rom_mem[i_bus.addr[ROM_ADDR_WIDTH-1:0]];
        end
    end

endmodule

/* hdl/interval_timer.sv */
`timescale 1ns/1ps

module interval_timer (
    input  logic              clk_2,
    input  logic              i_reset,
    input  logic              i_cs,
    input  soc_pkg::cpu_bus_t i_bus,
    output logic [7:0]        o_rdata,
    output logic              o_irqb
);

    logic [15:0] reload;
    logic [15:0] count;
    logic        enable;
    logic        irq_enable;
    logic        expired;

    logic [1:0]  reg_sel;
    logic        wr_en;
    logic        rd_en;
    logic        wrap;

    assign reg_sel = i_bus.addr[1:0];
    assign wr_en   = i_cs && !i_bus.rwb;
    assign rd_en   = i_cs && i_bus.rwb;
    assign wrap    = enable && (count == 16'd0);    // Expiry edge

    always_ff @(posedge clk_2) begin
        if (i_reset) begin
            reload     <= '0;
            count      <= '0;
            enable     <= 1'b0;
            irq_enable <= 1'b0;
            expired    <= 1'b0;
        end else begin
            if (wrap)
                count <= reload;
            else if (enable)
                count <= count - 16'd1;

            if (wrap)
                expired <= 1'b1;    // A new expiry beats a clear in the same cycle
            else if (wr_en && reg_sel == 2'd3 && i_bus.wdata[0])
                expired <= 1'b0;

            if (wr_en) begin
                case (reg_sel)
                    2'd0: reload[7:0]  <= i_bus.wdata;
                    2'd1: reload[15:8] <= i_bus.wdata;
                    2'd2: begin
                        enable     <= i_bus.wdata[0];
                        irq_enable <= i_bus.wdata[1];
                        if (i_bus.wdata[0])
                            count <= reload;    // Restart from reload
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk_2) begin
        if (rd_en) begin
            case (reg_sel)
                2'd0:    o_rdata <= reload[7:0];
                2'd1:    o_rdata <= reload[15:8];
                2'd2:    o_rdata <= {6'b0, irq_enable, enable};
                default: o_rdata <= {7'b0, expired};
            endcase
        end
    end

    assign o_irqb = ~(expired & irq_enable);

endmodule

/* hdl/multiplier.sv */
`timescale 1ns/1ps

module multiplier (
    input  logic              clk_2,
    input  logic              i_reset,
    input  logic              i_cs,
    input  soc_pkg::cpu_bus_t i_bus,
    output logic [7:0]        o_rdata
);

    logic [15:0] op_a;
    logic [15:0] op_b;
    logic [31:0] product;
    logic [2:0]  reg_sel;

    assign reg_sel = i_bus.addr[2:0];
    assign product = op_a * op_b;    // Unsigned, no pipeline

    always_ff @(posedge clk_2) begin
        if (i_reset) begin
            op_a <= '0;
            op_b <= '0;
        end else if (i_cs && !i_bus.rwb) begin
            case (reg_sel)
                3'd0:    op_a[7:0]  <= i_bus.wdata;
                3'd1:    op_a[15:8] <= i_bus.wdata;
                3'd2:    op_b[7:0]  <= i_bus.wdata;
                3'd3:    op_b[15:8] <= i_bus.wdata;
                default: ;    // Product bytes are read-only
            endcase
        end
    end

    always_ff @(posedge clk_2) begin
        if (i_cs && i_bus.rwb) begin
            case (reg_sel)
                3'd0: o_rdata <= op_a[7:0];
                3'd1: o_rdata <= op_a[15:8];
                3'd2: o_rdata <= op_b[7:0];
                3'd3: o_rdata <= op_b[15:8];
                3'd4: o_rdata <= product[7:0];
                3'd5: o_rdata <= product[15:8];
                3'd6: o_rdata <= product[23:16];
                3'd7: o_rdata <= product[31:24];
            endcase
        end
    end

endmodule

/* hdl/interrupt_controller.sv */
`timescale 1ns/1ps

module interrupt_controller #(
    parameter int IRQ_COUNT = 2
) (
    input  logic                 clk_2,
    input  logic                 i_reset,
    input  logic                 i_cs,
    input  soc_pkg::cpu_bus_t    i_bus,
    input  logic [IRQ_COUNT-1:0] i_src_irqb,
    output logic [7:0]           o_rdata,
    output logic                 o_irqb
);

    logic [IRQ_COUNT-1:0] mask;
    logic [IRQ_COUNT-1:0] pending;
    logic                 reg_sel;

    assign reg_sel = i_bus.addr[0];

    // Raw source state, the mask does not hide it
    assign pending = ~i_src_irqb;

    always_ff @(posedge clk_2) begin
        if (i_reset) begin
            mask <= '0;
        end else if (i_cs && !i_bus.rwb && reg_sel == 1'b0) begin
            mask <= i_bus.wdata[IRQ_COUNT-1:0];
        end
    end

    always_ff @(posedge clk_2) begin
        if (i_cs && i_bus.rwb) begin
            if (reg_sel)
                o_rdata <= 8'(pending);
            else
                o_rdata <= 8'(mask);
        end
    end

    // Any unmasked low source pulls the CPU line low
    assign o_irqb = ~|(pending & mask);

endmodule

/* hdl/soc_core.sv */
`timescale 1ns/1ps

module soc_core #(
    parameter int ROM_ADDR_WIDTH = 5,
    parameter int IRQ_COUNT      = 2
) (
    input  logic              clk_2,
    input  logic              i_reset,
    input  soc_pkg::cpu_bus_t i_bus,
    input  logic              i_ext_irqb,
    output logic [7:0]        o_rdata,
    output logic              o_irqb
);

    logic rom_cs;
    logic timer_cs;
    logic mult_cs;
    logic irq_cs;

    logic [7:0] rom_rdata;
    logic [7:0] timer_rdata;
    logic [7:0] mult_rdata;
    logic [7:0] irq_rdata;

    logic                 timer_irqb;
    logic [IRQ_COUNT-1:0] src_irqb;

    // Unused sources sit inactive
    always_comb begin
        src_irqb    = '1;
        src_irqb[0] = timer_irqb;
        src_irqb[1] = i_ext_irqb;
    end

    bus_decode bus_decode_i (
        .clk_2         (clk_2),
        .i_reset       (i_reset),
        .i_bus         (i_bus),
        .o_rom_cs      (rom_cs),
        .o_timer_cs    (timer_cs),
        .o_mult_cs     (mult_cs),
        .o_irq_cs      (irq_cs),
        .i_rom_rdata   (rom_rdata),
        .i_timer_rdata (timer_rdata),
        .i_mult_rdata  (mult_rdata),
        .i_irq_rdata   (irq_rdata),
        .o_rdata       (o_rdata)
    );

    boot_rom #(.ROM_ADDR_WIDTH(ROM_ADDR_WIDTH)) boot_rom_i (
        .clk_2(clk_2), .i_cs(rom_cs), .i_bus(i_bus), .o_rdata(rom_rdata)
    );

    interval_timer interval_timer_i (
        .clk_2(clk_2), .i_reset(i_reset), .i_cs(timer_cs), .i_bus(i_bus),
        .o_rdata(timer_rdata), .o_irqb(timer_irqb)
    );

    multiplier multiplier_i (
        .clk_2(clk_2), .i_reset(i_reset), .i_cs(mult_cs), .i_bus(i_bus),
        .o_rdata(mult_rdata)
    );

    interrupt_controller #(.IRQ_COUNT(IRQ_COUNT)) interrupt_controller_i (
        .clk_2(clk_2), .i_reset(i_reset), .i_cs(irq_cs), .i_bus(i_bus),
        .i_src_irqb(src_irqb), .o_rdata(irq_rdata), .o_irqb(o_irqb)
    );

endmodule

/* test/tb_soc_core.sv */
`timescale 1ns/1ps

module tb_soc_core;
    import soc_pkg::*;

    localparam int ROM_ADDR_WIDTH = 5;
    localparam int IRQ_COUNT      = 2;
    localparam int CLK_PERIOD     = 4;
    localparam int TEST_CYCLES    = 40 + 4200 + 520 + 40 + 60;    // Reset, ROM, mult, timer, irq
    localparam logic [15:0] UNMAPPED [6] = '{16'h0000, 16'h8000, 16'hC004, 16'hC007,
                                             16'hC012, 16'hEFFF};

    typedef struct packed {
        logic [15:0] reload;
        logic        enable;
        logic        irq_enable;
        logic        expired;
        logic [15:0] op_a;
        logic [15:0] op_b;
        logic [1:0]  mask;
        logic        ext_irqb;
    } model_t;

    logic       clk_2;
    logic       i_reset;
    cpu_bus_t   i_bus;
    logic       i_ext_irqb;
    logic [7:0] o_rdata;
    logic       o_irqb;

    logic [7:0] rom_model [0:(2**ROM_ADDR_WIDTH)-1];
    model_t     model;

    // Read driven this cycle, then the one whose data is on o_rdata
    logic        rd_issued;
    logic [15:0] rd_addr;
    logic [7:0]  rd_exp;
    logic        chk_valid;
    logic [15:0] chk_addr;
    logic [7:0]  chk_exp;

    soc_core #(.ROM_ADDR_WIDTH(ROM_ADDR_WIDTH), .IRQ_COUNT(IRQ_COUNT)) soc_core_i (
        .clk_2(clk_2), .i_reset(i_reset), .i_bus(i_bus), .i_ext_irqb(i_ext_irqb),
        .o_rdata(o_rdata), .o_irqb(o_irqb)
    );

    always #(CLK_PERIOD / 2) clk_2 = ~clk_2;

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s, got %0h, expected %0h",
                     $time, msg, actual, expected);
            $display("TESTS FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    function automatic logic [7:0] expected_read(input logic [15:0] addr, input model_t m);
        logic [31:0] product;
        product = 32'(m.op_a) * 32'(m.op_b);
        if (addr >= ROM_BASE)
            return rom_model[addr[ROM_ADDR_WIDTH-1:0]];    // Image repeats across the window
        case (addr)
            TIMER_BASE:         return m.reload[7:0];
            TIMER_BASE + 16'd1: return m.reload[15:8];
            TIMER_BASE + 16'd2: return {6'b0, m.irq_enable, m.enable};
            TIMER_BASE + 16'd3: return {7'b0, m.expired};
            MULT_BASE:          return m.op_a[7:0];
            MULT_BASE + 16'd1:  return m.op_a[15:8];
            MULT_BASE + 16'd2:  return m.op_b[7:0];
            MULT_BASE + 16'd3:  return m.op_b[15:8];
            MULT_BASE + 16'd4:  return product[7:0];
            MULT_BASE + 16'd5:  return product[15:8];
            MULT_BASE + 16'd6:  return product[23:16];
            MULT_BASE + 16'd7:  return product[31:24];
            IRQ_BASE:           return {6'b0, m.mask};
            IRQ_BASE + 16'd1:   return {6'b0, ~m.ext_irqb, m.expired & m.irq_enable};
            default:            return 8'h00;
        endcase
    endfunction

    task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
        @(negedge clk_2);
        i_bus     = '{addr: addr, wdata: data, rwb: 1'b0};
        rd_issued = 1'b0;
        case (addr)
            TIMER_BASE:         model.reload[7:0] = data;
            TIMER_BASE + 16'd1: model.reload[15:8] = data;
            TIMER_BASE + 16'd2: {model.irq_enable, model.enable} = data[1:0];
            TIMER_BASE + 16'd3: if (data[0]) model.expired = 1'b0;    // Write 1 to clear
            MULT_BASE:          model.op_a[7:0] = data;
            MULT_BASE + 16'd1:  model.op_a[15:8] = data;
            MULT_BASE + 16'd2:  model.op_b[7:0] = data;
            MULT_BASE + 16'd3:  model.op_b[15:8] = data;
            IRQ_BASE:           model.mask = data[1:0];
            default: ;
        endcase
    endtask

    task automatic read_reg(input logic [15:0] addr);
        @(negedge clk_2);
        i_bus     = '{addr: addr, wdata: 8'h00, rwb: 1'b1};
        rd_issued = 1'b1;
        rd_addr   = addr;
        rd_exp    = expected_read(addr, model);
    endtask

    task automatic read_range(input logic [15:0] base, input int count);
        for (int i = 0; i < count; i++)
            read_reg(base + 16'(i));
    endtask

    task automatic idle_cycle();
        @(negedge clk_2);
        i_bus     = '{addr: 16'h0000, wdata: 8'h00, rwb: 1'b1};
        rd_issued = 1'b0;
    endtask

    task automatic drive_ext_irq(input logic level);
        idle_cycle();
        i_ext_irqb     = level;
        model.ext_irqb = level;
    endtask

    task automatic verify_irqb(input logic expected, input string msg);
        check_equal(32'(o_irqb), 32'(expected), msg);
    endtask

    always @(posedge clk_2) begin
        chk_valid <= rd_issued;
        chk_addr  <= rd_addr;
        chk_exp   <= rd_exp;
    end

    // Data of a read is checked mid-cycle, one cycle after it was driven
    always @(negedge clk_2) begin
        if (chk_valid === 1'b1)
            check_equal(32'(o_rdata), 32'(chk_exp), $sformatf("read of %h", chk_addr));
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d ns", 2 * TEST_CYCLES * CLK_PERIOD);
        $display("TESTS FAILED");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        int          reload_val;
        void'($urandom(41201));
        clk_2          = 1'b0;
        i_reset        = 1'b1;
        i_bus          = '{addr: 16'h0000, wdata: 8'h00, rwb: 1'b1};
        i_ext_irqb     = 1'b1;
        rd_issued      = 1'b0;
        rd_addr        = '0;
        rd_exp         = '0;
        model          = '0;
        model.ext_irqb = 1'b1;
        $readmemh("boot_rom.hex", rom_model);
        repeat (2) @(negedge clk_2);
        i_reset = 1'b0;

        // Reset values and unmapped holes
        idle_cycle();
        check_equal(32'(o_rdata), 32'h0, "o_rdata after reset");
        verify_irqb(1'b1, "o_irqb after reset");
        read_range(TIMER_BASE, 4);
        read_range(MULT_BASE, 8);
        read_range(IRQ_BASE, 2);
        foreach (UNMAPPED[i])
            read_reg(UNMAPPED[i]);

        // Whole ROM window back to back, then writes that must not stick
        for (int addr = ROM_BASE; addr < 32'h10000; addr++)
            read_reg(16'(addr));
        write_reg(16'hF003, ~rom_model[3]);
        write_reg(16'hFFFF, ~rom_model[31]);
        read_range(16'hF000, 2**ROM_ADDR_WIDTH);
        read_range(16'hFFE0, 2**ROM_ADDR_WIDTH);

        for (int n = 0; n < 50; n++) begin
            a = (n == 0) ? 16'hFFFF : 16'($urandom);
            b = (n == 0) ? 16'hFFFF : 16'($urandom);
            write_reg(MULT_BASE, a[7:0]);
            write_reg(MULT_BASE + 16'd1, a[15:8]);
            write_reg(MULT_BASE + 16'd2, b[7:0]);
            write_reg(MULT_BASE + 16'd3, b[15:8]);
            read_range(MULT_BASE + 16'd4, 4);
        end
        read_range(MULT_BASE, 4);

        // Timer expiry, flag seen by a read k edges after the enabling write
        reload_val = 3 + int'($urandom % 8);
        write_reg(TIMER_BASE, 8'(reload_val));
        write_reg(TIMER_BASE + 16'd1, 8'(reload_val >> 8));
        write_reg(TIMER_BASE + 16'd2, 8'h03);
        for (int k = 1; k <= reload_val + 4; k++) begin
            model.expired = (k >= reload_val + 2);    // Set at edge reload+1
            read_reg(TIMER_BASE + 16'd3);
        end
        verify_irqb(1'b1, "o_irqb with the timer source masked");
        write_reg(IRQ_BASE, 8'h01);
        idle_cycle();
        verify_irqb(1'b0, "o_irqb with the timer source unmasked");
        read_reg(IRQ_BASE + 16'd1);
        write_reg(TIMER_BASE + 16'd2, 8'h02);
        write_reg(TIMER_BASE + 16'd3, 8'h01);
        idle_cycle();
        verify_irqb(1'b1, "o_irqb after clearing expired");
        read_range(TIMER_BASE, 4);

        // External source against the mask, with other traffic in between
        write_reg(IRQ_BASE, 8'h00);
        drive_ext_irq(1'b0);
        read_reg(IRQ_BASE + 16'd1);
        verify_irqb(1'b1, "o_irqb with the external source masked");
        write_reg(MULT_BASE, 8'($urandom));
        write_reg(IRQ_BASE, 8'h02);
        read_reg(MULT_BASE);
        verify_irqb(1'b0, "o_irqb with the external source unmasked");
        write_reg(TIMER_BASE, 8'($urandom));
        read_range(TIMER_BASE, 2);
        read_range(IRQ_BASE, 2);
        write_reg(IRQ_BASE, 8'h01);
        idle_cycle();
        verify_irqb(1'b1, "o_irqb with only the timer unmasked");
        drive_ext_irq(1'b1);
        write_reg(IRQ_BASE, 8'h03);
        idle_cycle();
        verify_irqb(1'b1, "o_irqb with both sources idle");
        read_range(TIMER_BASE, 4);
        read_range(MULT_BASE, 8);
        read_range(IRQ_BASE, 2);
        idle_cycle();
        idle_cycle();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* boot_rom.hex */
// Boot ROM image, one hex byte per line, ROM offset 00 first
// Offsets 1A to 1F hold the NMI, RESET and IRQ vectors
78
D8
A2
FF
9A
A9
00
8D
10
C0
A9
20
8D
00
C0
A9
00
8D
01
C0
A9
03
8D
02
C0
58
00
F0
00
F0
00
F0

/* tb.f */
hdl/soc_pkg.sv
hdl/bus_decode.sv
hdl/boot_rom.sv
hdl/interval_timer.sv
hdl/multiplier.sv
hdl/interrupt_controller.sv
hdl/soc_core.sv
test/tb_soc_core.sv

/* run_sim.sh */
#!/bin/sh
# Build and run from the project root so boot_rom.hex is found
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -f tb.f --top-module tb_soc_core -o tb_soc_core \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_soc_core > sim.log 2>&1
grep -q "TESTS FAILED" sim.log && { echo "Simulation failed, see sim.log"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "Simulation ended early, see sim.log"; exit 1; }
echo "Simulation passed"
